/* src/csr_settings.svh */
`ifndef CSR_SETTINGS_SVH
`define CSR_SETTINGS_SVH

`define CSR_XLEN            64
`define CSR_ADDR_W          12

`define CSR_ADDR_MSTATUS    12'h300
`define CSR_ADDR_MISA       12'h301
`define CSR_ADDR_MIE        12'h304
`define CSR_ADDR_MTVEC      12'h305
`define CSR_ADDR_MSCRATCH   12'h340
`define CSR_ADDR_MEPC       12'h341
`define CSR_ADDR_MCAUSE     12'h342
`define CSR_ADDR_MTVAL      12'h343

`define CSR_MSTATUS_MIE_BIT   3
`define CSR_MSTATUS_MPIE_BIT  7
`define CSR_MSTATUS_MPP_BIT   11
`define CSR_MSTATUS_UXL_BIT   32
`define CSR_MCAUSE_INT_BIT    63

`define CSR_EXC_NONE        4'hf

`define CSR_PRIV_M          2'd3
`define CSR_PRIV_U          2'd0

`endif

/* src/csr_pkg.sv */
`default_nettype none

`include "csr_settings.svh"

package csr_pkg;

    typedef logic [3:0] exc_code_t;
    typedef logic [1:0] priv_t;

    // field view of mstatus, msb first
    typedef struct packed {
        logic [`CSR_XLEN-1:`CSR_MSTATUS_UXL_BIT+2]              rsv_hi;
        logic [1:0]                                             uxl;
        logic [`CSR_MSTATUS_UXL_BIT-1:`CSR_MSTATUS_MPP_BIT+2]   rsv_mid;
        logic [1:0]                                             mpp;
        logic [`CSR_MSTATUS_MPP_BIT-1:`CSR_MSTATUS_MPIE_BIT+1]  rsv_spp;
        logic                                                   mpie;
        logic [`CSR_MSTATUS_MPIE_BIT-1:`CSR_MSTATUS_MIE_BIT+1]  rsv_ube;
        logic                                                   mie;
        logic [`CSR_MSTATUS_MIE_BIT-1:0]                        rsv_lo;
    } mstatus_fields_t;

    // software sees the raw word, trap logic the fields
    typedef union packed {
        logic [`CSR_XLEN-1:0] raw;
        mstatus_fields_t      fields;
    } mstatus_u;

endpackage

`default_nettype wire

/* src/csr_trap_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

`include "csr_settings.svh"

module csr_trap_ctrl (
    input  wire                     i_clk,
    input  wire                     i_rst,
    input  wire                     i_clk_en,
    input  wire csr_pkg::exc_code_t i_exc_code_fd,
    input  wire [`CSR_XLEN-1:0]     i_exc_pc_fd,
    input  wire csr_pkg::exc_code_t i_exc_code_em,
    input  wire [`CSR_XLEN-1:0]     i_exc_pc_em,
    input  wire [`CSR_XLEN-1:0]     i_exc_addr_em,
    input  wire                     i_mret,
    input  wire csr_pkg::priv_t     i_current_priv,
    input  wire csr_pkg::mstatus_u  i_mstatus,
    output logic                    o_trap_take,
    output logic [`CSR_XLEN-1:0]    o_trap_epc,
    output csr_pkg::exc_code_t      o_trap_cause,
    output logic [`CSR_XLEN-1:0]    o_trap_tval,
    output logic                    o_mret_take,
    output csr_pkg::priv_t          o_new_priv
);
    import csr_pkg::*;

    logic  fd_valid;
    logic  em_valid;
    priv_t priv_q;

    assign fd_valid = (i_exc_code_fd != `CSR_EXC_NONE);
    assign em_valid = (i_exc_code_em != `CSR_EXC_NONE);

    always_comb
    begin
        o_trap_take = i_clk_en & (fd_valid | em_valid);
        o_mret_take = i_clk_en & i_mret & ~fd_valid & ~em_valid;
        if (fd_valid) // fetch fault has priority
        begin
            o_trap_epc   = i_exc_pc_fd;
            o_trap_cause = i_exc_code_fd;
            o_trap_tval  = i_exc_pc_fd; // faulting pc
        end
        else
        begin
            o_trap_epc   = i_exc_pc_em;
            o_trap_cause = i_exc_code_em;
            o_trap_tval  = i_exc_addr_em; // faulting data address
        end
    end

    always_ff @(posedge i_clk)
    begin
        if (i_rst)
            priv_q <= `CSR_PRIV_M;
        else if (o_trap_take)
            priv_q <= `CSR_PRIV_M;
        else if (o_mret_take)
            priv_q <= i_mstatus.fields.mpp; // back to the level before the trap
    end

    assign o_new_priv = priv_q;

endmodule

`default_nettype wire

/* src/csr_regs.sv */
`timescale 1ns/1ps
`default_nettype none

`include "csr_settings.svh"

module csr_regs (
    input  wire                     i_clk,
    input  wire                     i_rst,
    input  wire                     i_clk_en,
    input  wire                     i_write_en,
    input  wire [`CSR_ADDR_W-1:0]   i_write_addr,
    input  wire [`CSR_XLEN-1:0]     i_write_data,
    input  wire csr_pkg::priv_t     i_current_priv,
    input  wire                     i_trap_take,
    input  wire [`CSR_XLEN-1:0]     i_trap_epc,
    input  wire csr_pkg::exc_code_t i_trap_cause,
    input  wire [`CSR_XLEN-1:0]     i_trap_tval,
    input  wire                     i_mret_take,
    output csr_pkg::mstatus_u       o_mstatus,
    output logic [`CSR_XLEN-1:0]    o_misa,
    output logic [`CSR_XLEN-1:0]    o_mie,
    output logic [`CSR_XLEN-1:0]    o_mtvec,
    output logic [`CSR_XLEN-1:0]    o_mscratch,
    output logic [`CSR_XLEN-1:0]    o_mepc,
    output logic [`CSR_XLEN-1:0]    o_mcause,
    output logic [`CSR_XLEN-1:0]    o_mtval
);
    import csr_pkg::*;

    mstatus_u             mstatus_trap;
    mstatus_u             mstatus_ret;
    logic [`CSR_XLEN-1:0] mcause_trap;

    always_comb
    begin
        mstatus_trap = o_mstatus;
        mstatus_trap.fields.mie  = 1'b0;
        mstatus_trap.fields.mpie = o_mstatus.fields.mie;
        mstatus_trap.fields.mpp  = i_current_priv;

        mstatus_ret = o_mstatus;
        mstatus_ret.fields.mie = o_mstatus.fields.mpie;
        mstatus_ret.fields.mpp = i_current_priv;

        mcause_trap = '0;
        mcause_trap[3:0] = i_trap_cause;
        mcause_trap[`CSR_MCAUSE_INT_BIT] = 1'b0; // exceptions only, no interrupts
    end

    always_ff @(posedge i_clk)
    begin
        if (i_rst)
        begin
            o_mstatus  <= '0;
            o_misa     <= '0;
            o_mie      <= '0;
            o_mtvec    <= '0;
            o_mscratch <= '0;
            o_mepc     <= '0;
            o_mcause   <= '0;
            o_mtval    <= '0;
        end
        else
        begin
            if (i_clk_en && i_write_en)
            begin
                case (i_write_addr)
                    `CSR_ADDR_MSTATUS:  o_mstatus.raw <= i_write_data;
                    `CSR_ADDR_MISA:     o_misa        <= i_write_data;
                    `CSR_ADDR_MIE:      o_mie         <= i_write_data;
                    `CSR_ADDR_MTVEC:    o_mtvec       <= i_write_data;
                    `CSR_ADDR_MSCRATCH: o_mscratch    <= i_write_data;
                    `CSR_ADDR_MEPC:     o_mepc        <= i_write_data;
                    `CSR_ADDR_MCAUSE:   o_mcause      <= i_write_data;
                    `CSR_ADDR_MTVAL:    o_mtval       <= i_write_data;
                    default: ; // unmapped, dropped
                endcase
            end

            // later assignments override a same-cycle software write
            if (i_trap_take)
            begin
                o_mstatus <= mstatus_trap;
                o_mepc    <= i_trap_epc;
                o_mcause  <= mcause_trap;
                o_mtval   <= i_trap_tval;
            end
            else if (i_mret_take)
                o_mstatus <= mstatus_ret;
        end
    end

endmodule

`default_nettype wire

/* src/csr_read_mux.sv */
`timescale 1ns/1ps
`default_nettype none

`include "csr_settings.svh"

module csr_read_mux (
    input  wire [`CSR_ADDR_W-1:0]  i_read_addr,
    input  wire csr_pkg::mstatus_u i_mstatus,
    input  wire [`CSR_XLEN-1:0]    i_misa,
    input  wire [`CSR_XLEN-1:0]    i_mie,
    input  wire [`CSR_XLEN-1:0]    i_mtvec,
    input  wire [`CSR_XLEN-1:0]    i_mscratch,
    input  wire [`CSR_XLEN-1:0]    i_mepc,
    input  wire [`CSR_XLEN-1:0]    i_mcause,
    input  wire [`CSR_XLEN-1:0]    i_mtval,
    output logic [`CSR_XLEN-1:0]   o_read_data
);

    always_comb
    begin
        case (i_read_addr)
            `CSR_ADDR_MSTATUS:  o_read_data = i_mstatus.raw;
            `CSR_ADDR_MISA:     o_read_data = i_misa;
            `CSR_ADDR_MIE:      o_read_data = i_mie;
            `CSR_ADDR_MTVEC:    o_read_data = i_mtvec;
            `CSR_ADDR_MSCRATCH: o_read_data = i_mscratch;
            `CSR_ADDR_MEPC:     o_read_data = i_mepc;
            `CSR_ADDR_MCAUSE:   o_read_data = i_mcause;
            `CSR_ADDR_MTVAL:    o_read_data = i_mtval;
            default:            o_read_data = '0; // id csrs and the rest read zero
        endcase
    end

endmodule

`default_nettype wire

/* src/csr_file.sv */
`timescale 1ns/1ps
`default_nettype none

`include "csr_settings.svh"

module csr_file (
    input  wire                     i_clk,
    input  wire                     i_rst,
    input  wire                     i_clk_en,
    input  wire [`CSR_ADDR_W-1:0]   i_csr_write_addr,
    input  wire [`CSR_ADDR_W-1:0]   i_csr_read_addr,
    input  wire                     i_csr_write_en,
    input  wire [`CSR_XLEN-1:0]     i_csr_data,
    input  wire csr_pkg::exc_code_t i_exc_code_fd,
    input  wire [`CSR_XLEN-1:0]     i_exc_pc_fd,
    input  wire csr_pkg::exc_code_t i_exc_code_em,
    input  wire [`CSR_XLEN-1:0]     i_exc_pc_em,
    input  wire [`CSR_XLEN-1:0]     i_exc_addr_em,
    input  wire                     i_mret,
    input  wire csr_pkg::priv_t     i_current_priv,
    output logic [`CSR_XLEN-1:0]    o_csr_data,
    output logic [`CSR_XLEN-1:0]    o_mepc,
    output logic [`CSR_XLEN-1:0]    o_mtvec,
    output logic [1:0]              o_uxl,
    output csr_pkg::priv_t          o_new_priv
);
    import csr_pkg::*;

    logic                 trap_take;
    logic [`CSR_XLEN-1:0] trap_epc;
    exc_code_t            trap_cause;
    logic [`CSR_XLEN-1:0] trap_tval;
    logic                 mret_take;
    mstatus_u             mstatus;
    logic [`CSR_XLEN-1:0] misa;
    logic [`CSR_XLEN-1:0] mie;
    logic [`CSR_XLEN-1:0] mscratch;
    logic [`CSR_XLEN-1:0] mcause;
    logic [`CSR_XLEN-1:0] mtval;

    csr_trap_ctrl u_trap_ctrl (
        .i_clk          (i_clk),
        .i_rst          (i_rst),
        .i_clk_en       (i_clk_en),
        .i_exc_code_fd  (i_exc_code_fd),
        .i_exc_pc_fd    (i_exc_pc_fd),
        .i_exc_code_em  (i_exc_code_em),
        .i_exc_pc_em    (i_exc_pc_em),
        .i_exc_addr_em  (i_exc_addr_em),
        .i_mret         (i_mret),
        .i_current_priv (i_current_priv),
        .i_mstatus      (mstatus),
        .o_trap_take    (trap_take),
        .o_trap_epc     (trap_epc),
        .o_trap_cause   (trap_cause),
        .o_trap_tval    (trap_tval),
        .o_mret_take    (mret_take),
        .o_new_priv     (o_new_priv)
    );

    csr_regs u_regs (
        .i_clk          (i_clk),
        .i_rst          (i_rst),
        .i_clk_en       (i_clk_en),
        .i_write_en     (i_csr_write_en),
        .i_write_addr   (i_csr_write_addr),
        .i_write_data   (i_csr_data),
        .i_current_priv (i_current_priv),
        .i_trap_take    (trap_take),
        .i_trap_epc     (trap_epc),
        .i_trap_cause   (trap_cause),
        .i_trap_tval    (trap_tval),
        .i_mret_take    (mret_take),
        .o_mstatus      (mstatus),
        .o_misa         (misa),
        .o_mie          (mie),
        .o_mtvec        (o_mtvec),
        .o_mscratch     (mscratch),
        .o_mepc         (o_mepc),
        .o_mcause       (mcause),
        .o_mtval        (mtval)
    );

    csr_read_mux u_read_mux (
        .i_read_addr (i_csr_read_addr),
        .i_mstatus   (mstatus),
        .i_misa      (misa),
        .i_mie       (mie),
        .i_mtvec     (o_mtvec),
        .i_mscratch  (mscratch),
        .i_mepc      (o_mepc),
        .i_mcause    (mcause),
        .i_mtval     (mtval),
        .o_read_data (o_csr_data)
    );

    assign o_uxl = mstatus.fields.uxl; // user xlen straight from mstatus

endmodule

`default_nettype wire

/* verif/tb_clk_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen (
    output logic o_clk,
    output logic o_rst
);

    initial
    begin
        o_clk = 1'b0;
        forever #5 o_clk = ~o_clk; // 10 ns period
    end

    initial
    begin
        o_rst = 1'b1;
        repeat (10) @(posedge o_clk);
        #1 o_rst = 1'b0; // released just after the tenth edge
    end

endmodule

`default_nettype wire

/* verif/tb_csr_file.sv */
`timescale 1ns/1ps
`default_nettype none

`include "csr_settings.svh"

module tb_csr_file;

    localparam int         MAX_CYCLES = 2000; // the tests take about 1200
    localparam logic [3:0] MSTATUS    = 4'd0;
    localparam logic [3:0] MTVEC      = 4'd3;
    localparam logic [3:0] MEPC       = 4'd5;
    localparam logic [3:0] MCAUSE     = 4'd6;
    localparam logic [3:0] MTVAL      = 4'd7;
    localparam logic [`CSR_ADDR_W-1:0] CSR_ADDRS [0:7] = '{
        `CSR_ADDR_MSTATUS, `CSR_ADDR_MISA, `CSR_ADDR_MIE, `CSR_ADDR_MTVEC,
        `CSR_ADDR_MSCRATCH, `CSR_ADDR_MEPC, `CSR_ADDR_MCAUSE, `CSR_ADDR_MTVAL
    };

    logic                   clk;
    logic                   rst;
    logic                   clk_en;
    logic [`CSR_ADDR_W-1:0] write_addr;
    logic [`CSR_ADDR_W-1:0] read_addr;
    logic                   write_en;
    logic [`CSR_XLEN-1:0]   wdata;
    logic [3:0]             code_fd;
    logic [`CSR_XLEN-1:0]   pc_fd;
    logic [3:0]             code_em;
    logic [`CSR_XLEN-1:0]   pc_em;
    logic [`CSR_XLEN-1:0]   addr_em;
    logic                   mret;
    logic [1:0]             cur_priv;
    logic [`CSR_XLEN-1:0]   rdata;
    logic [`CSR_XLEN-1:0]   mepc_out;
    logic [`CSR_XLEN-1:0]   mtvec_out;
    logic [1:0]             uxl_out;
    logic [1:0]             priv_out;

    logic [`CSR_XLEN-1:0]   m_csr [0:15]; // slots 8..15 unused
    logic [1:0]             m_priv;
    int                     seed = 32'hecd;
    int                     error_count = 0;
    int                     check_count = 0;
    int                     cycles = 0;

    tb_clk_gen u_clk_gen (
        .o_clk (clk),
        .o_rst (rst)
    );

    csr_file i_csr_file (
        .i_clk            (clk),
        .i_rst            (rst),
        .i_clk_en         (clk_en),
        .i_csr_write_addr (write_addr),
        .i_csr_read_addr  (read_addr),
        .i_csr_write_en   (write_en),
        .i_csr_data       (wdata),
        .i_exc_code_fd    (code_fd),
        .i_exc_pc_fd      (pc_fd),
        .i_exc_code_em    (code_em),
        .i_exc_pc_em      (pc_em),
        .i_exc_addr_em    (addr_em),
        .i_mret           (mret),
        .i_current_priv   (cur_priv),
        .o_csr_data       (rdata),
        .o_mepc           (mepc_out),
        .o_mtvec          (mtvec_out),
        .o_uxl            (uxl_out),
        .o_new_priv       (priv_out)
    );

    function automatic logic [`CSR_XLEN-1:0] rand64();
        return {$random(seed), $random(seed)};
    endfunction

    // index 8 stands for any unmapped address
    function automatic logic [3:0] csr_index(input logic [`CSR_ADDR_W-1:0] addr);
        for (int k = 0; k < 8; k++)
            if (CSR_ADDRS[k[2:0]] == addr)
                return k[3:0];
        return 4'd8;
    endfunction

    function automatic logic [`CSR_ADDR_W-1:0] addr_of(input logic [3:0] k);
        if (k[3])
            return {4'h7, k, 4'h5}; // nothing mapped at 0x7x5
        return CSR_ADDRS[k[2:0]];
    endfunction

    function automatic logic [`CSR_ADDR_W-1:0] pick_addr();
        logic [31:0] r;
        r = $random(seed);
        return addr_of(r[3:0]);
    endfunction

    function automatic logic [`CSR_XLEN-1:0] model_read(input logic [`CSR_ADDR_W-1:0] addr);
        logic [3:0] idx;
        idx = csr_index(addr);
        return idx[3] ? '0 : m_csr[idx];
    endfunction

    // one clock edge of the CSR file, from the inputs currently driven
    function automatic void model_step();
        logic [`CSR_XLEN-1:0] old_st;
        logic [3:0]           idx;
        logic                 fd;
        old_st = m_csr[MSTATUS];
        idx    = csr_index(write_addr);
        fd     = (code_fd != `CSR_EXC_NONE);
        if (!clk_en)
            return; // stall
        if (write_en && !idx[3])
            m_csr[idx] = wdata;
        if (fd || code_em != `CSR_EXC_NONE)
        begin
            m_csr[MSTATUS] = old_st; // trap beats a same-cycle mstatus write
            m_csr[MSTATUS][`CSR_MSTATUS_MPIE_BIT]   = old_st[`CSR_MSTATUS_MIE_BIT];
            m_csr[MSTATUS][`CSR_MSTATUS_MIE_BIT]    = 1'b0;
            m_csr[MSTATUS][`CSR_MSTATUS_MPP_BIT+:2] = cur_priv;
            m_csr[MEPC]   = fd ? pc_fd : pc_em;
            m_csr[MCAUSE] = {60'd0, fd ? code_fd : code_em};
            m_csr[MTVAL]  = fd ? pc_fd : addr_em;
            m_priv        = `CSR_PRIV_M;
        end
        else if (mret)
        begin
            m_priv         = old_st[`CSR_MSTATUS_MPP_BIT+:2];
            m_csr[MSTATUS] = old_st;
            m_csr[MSTATUS][`CSR_MSTATUS_MIE_BIT]    = old_st[`CSR_MSTATUS_MPIE_BIT];
            m_csr[MSTATUS][`CSR_MSTATUS_MPP_BIT+:2] = cur_priv;
        end
    endfunction

    task automatic check_eq(input string name, input logic [`CSR_XLEN-1:0] got,
                            input logic [`CSR_XLEN-1:0] exp);
        check_count++;
        if (got !== exp)
        begin
            error_count++;
            $display("Error at %0t: %s is %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic drive_idle();
        clk_en   = 1'b1;
        write_en = 1'b0;
        mret     = 1'b0;
        code_fd  = `CSR_EXC_NONE;
        code_em  = `CSR_EXC_NONE;
    endtask

    always @(posedge clk)
    begin
        if (rst)
        begin
            m_csr  = '{default: '0};
            m_priv = `CSR_PRIV_M;
        end
        else
            model_step();
    end

    // outputs are settled at the falling edge
    always @(negedge clk)
    begin
        if (!rst)
        begin
            check_eq("o_csr_data", rdata, model_read(read_addr));
            check_eq("o_mepc", mepc_out, m_csr[MEPC]);
            check_eq("o_mtvec", mtvec_out, m_csr[MTVEC]);
            check_eq("o_uxl", {62'd0, uxl_out},
                     {62'd0, m_csr[MSTATUS][`CSR_MSTATUS_UXL_BIT+:2]});
            check_eq("o_new_priv", {62'd0, priv_out}, {62'd0, m_priv});
        end
    end

    always @(posedge clk)
    begin
        cycles <= cycles + 1;
        if (cycles == MAX_CYCLES)
        begin
            $display("Timeout: the run did not finish within %0d cycles", MAX_CYCLES);
            $display("Test failed");
            $finish;
        end
    end

    initial
    begin
        logic [31:0] r;
        write_addr = '0;
        read_addr  = '0;
        wdata      = '0;
        pc_fd      = '0;
        pc_em      = '0;
        addr_em    = '0;
        cur_priv   = `CSR_PRIV_U;
        drive_idle();
        wait (rst === 1'b0);

        for (int k = 0; k < 10; k++)
        begin
            read_addr = addr_of(k[3:0]); // all zero after reset
            next_cycle();
        end

        repeat (40)
        begin
            r          = $random(seed);
            write_addr = pick_addr();
            read_addr  = write_addr;
            wdata      = rand64();
            write_en   = 1'b1;
            clk_en     = (r[1:0] != 2'd0); // some writes stalled
            next_cycle();
            drive_idle();
            next_cycle();
        end

        // fetch fault from user mode with mie set
        wdata      = rand64();
        wdata[`CSR_MSTATUS_MPP_BIT+:2] = `CSR_PRIV_U;
        write_addr = `CSR_ADDR_MSTATUS;
        read_addr  = `CSR_ADDR_MSTATUS;
        write_en   = 1'b1;
        next_cycle();
        write_en   = 1'b0;
        mret       = 1'b1; // drop to user first
        next_cycle();
        mret       = 1'b0;
        wdata      = rand64();
        wdata[`CSR_MSTATUS_MIE_BIT]    = 1'b1;
        wdata[`CSR_MSTATUS_MPIE_BIT]   = 1'b0;
        wdata[`CSR_MSTATUS_MPP_BIT+:2] = `CSR_PRIV_M;
        write_en   = 1'b1;
        next_cycle();
        check_eq("o_new_priv before trap", {62'd0, priv_out}, {62'd0, `CSR_PRIV_U});
        write_en   = 1'b0;
        code_fd    = 4'h1;
        pc_fd      = rand64();
        next_cycle();
        check_eq("mstatus.mie after trap", {63'd0, rdata[`CSR_MSTATUS_MIE_BIT]}, 64'd0);
        check_eq("mstatus.mpie after trap", {63'd0, rdata[`CSR_MSTATUS_MPIE_BIT]}, 64'd1);
        check_eq("mstatus.mpp after trap", {62'd0, rdata[`CSR_MSTATUS_MPP_BIT+:2]}, 64'd0);
        check_eq("o_new_priv after trap", {62'd0, priv_out}, {62'd0, `CSR_PRIV_M});
        drive_idle();
        read_addr = `CSR_ADDR_MCAUSE;
        next_cycle();
        read_addr = `CSR_ADDR_MTVAL;
        next_cycle();

        // execute fault, then both stages at once with writes
        code_em   = 4'h5;
        pc_em     = rand64();
        addr_em   = rand64();
        next_cycle();
        code_fd    = 4'h1;
        pc_fd      = rand64();
        code_em    = 4'h7;
        addr_em    = rand64();
        write_en   = 1'b1;
        write_addr = `CSR_ADDR_MSCRATCH;
        wdata      = rand64();
        next_cycle();
        code_fd    = `CSR_EXC_NONE;
        write_addr = `CSR_ADDR_MEPC; // lost to the trap
        wdata      = rand64();
        next_cycle();
        drive_idle();
        read_addr = `CSR_ADDR_MSCRATCH;
        next_cycle();
        read_addr = `CSR_ADDR_MCAUSE;
        next_cycle();

        // mret back to user, then mret together with an exception
        wdata      = rand64();
        wdata[`CSR_MSTATUS_MIE_BIT]    = 1'b0;
        wdata[`CSR_MSTATUS_MPIE_BIT]   = 1'b1;
        wdata[`CSR_MSTATUS_MPP_BIT+:2] = `CSR_PRIV_U;
        write_addr = `CSR_ADDR_MSTATUS;
        read_addr  = `CSR_ADDR_MSTATUS;
        write_en   = 1'b1;
        next_cycle();
        write_en   = 1'b0;
        cur_priv   = `CSR_PRIV_M;
        mret       = 1'b1;
        next_cycle();
        check_eq("o_new_priv after mret", {62'd0, priv_out}, {62'd0, `CSR_PRIV_U});
        code_em    = 4'h2;
        pc_em      = rand64();
        addr_em    = rand64();
        next_cycle();
        drive_idle();
        next_cycle();

        repeat (1000)
        begin
            r          = $random(seed);
            clk_en     = (r[2:0] != 3'd0);
            write_en   = r[3];
            mret       = (r[6:4] == 3'd0);
            code_fd    = (r[10:8] == 3'd0) ? r[15:12] : `CSR_EXC_NONE;
            code_em    = (r[18:16] == 3'd0) ? r[23:20] : `CSR_EXC_NONE;
            cur_priv   = r[24] ? `CSR_PRIV_M : `CSR_PRIV_U;
            write_addr = pick_addr();
            read_addr  = pick_addr();
            wdata      = rand64();
            pc_fd      = rand64();
            pc_em      = rand64();
            addr_em    = rand64();
            next_cycle();
        end
        drive_idle();
        @(negedge clk);

        $display("Checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0)
            $display("Test passed");
        else
            $display("Test failed");
        $finish;
    end

endmodule

`default_nettype wire

/* tb.f */
+incdir+src
src/csr_pkg.sv
src/csr_trap_ctrl.sv
src/csr_regs.sv
src/csr_read_mux.sv
src/csr_file.sv
verif/tb_clk_gen.sv
verif/tb_csr_file.sv

/* Makefile */
SIM = obj_dir/Vtb_csr_file

all: run

$(SIM): tb.f $(wildcard src/*.sv src/*.svh verif/*.sv)
	verilator --binary --timescale 1ns/1ps -f tb.f --top-module tb_csr_file -o Vtb_csr_file

run: $(SIM)
	$(SIM) | tee sim.log
	grep -qx "Test passed" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: all run clean
